// ==== design/scb_cfg_pkg.sv ====
package scb_cfg_pkg;

    // sid is one wrap bit above SID_W index bits
    localparam int SID_W = 4;

    typedef logic [SID_W:0] sid_t;

    localparam int NUM_UNITS = 4;

    // unit order
    localparam int UNIT_ALU0 = 0;
    localparam int UNIT_ALU1 = 1;
    localparam int UNIT_BEU  = 2;
    localparam int UNIT_LSU  = 3;

    // one-hot grant or zero
    typedef logic [NUM_UNITS-1:0] unit_mask_t;

    // true when a was issued after b
    function automatic logic sid_newer(sid_t a, sid_t b);
        logic [SID_W-1:0] idx_a;
        logic [SID_W-1:0] idx_b;
        idx_a = a[SID_W-1:0];
        idx_b = b[SID_W-1:0];
        if (a[SID_W] == b[SID_W]) begin
            return idx_a > idx_b;
        end
        // counter wrapped between the two
        return idx_a < idx_b;
    endfunction

endpackage

// ==== design/rv_pkg.sv ====
package rv_pkg;

    // architectural register number, x0 to x31
    typedef logic [4:0] reg_idx_t;

    localparam int EXE_CLASS_W = 6;

    // decoder class flags, one per execution class
    typedef logic [EXE_CLASS_W-1:0] exe_class_t;

    localparam int CLS_ALU = 0;
    localparam int CLS_BEU = 1;
    localparam int CLS_LSU = 2;

endpackage

// ==== design/scb_entry.sv ====
`timescale 1ns/100ps

module scb_entry (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_i,
    input  rv_pkg::reg_idx_t  alloc_rd_i,
    input  scb_cfg_pkg::sid_t alloc_sid_i,
    input  logic              release_i,
    output logic              busy_o,
    output rv_pkg::reg_idx_t  rd_o,
    output scb_cfg_pkg::sid_t sid_o
);

    // allocate wins over a release in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o <= 1'b0;
        end else if (alloc_i) begin
            busy_o <= 1'b1;
        end else if (release_i) begin
            busy_o <= 1'b0;
        end
    end

    // record of the instruction holding this unit
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_o  <= alloc_rd_i;
            sid_o <= alloc_sid_i;
        end
    end

endmodule

// ==== design/issue_ctrl.sv ====
`timescale 1ns/100ps

module issue_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec0_vld_i,
    input  rv_pkg::exe_class_t      dec0_class_i,
    input  rv_pkg::reg_idx_t        dec0_rd_i,
    input  logic                    dec1_vld_i,
    input  rv_pkg::exe_class_t      dec1_class_i,
    input  rv_pkg::reg_idx_t        dec1_rd_i,
    input  logic                    op_stall0_i,
    input  logic                    op_stall1_i,
    input  scb_cfg_pkg::unit_mask_t busy_i,
    input  rv_pkg::reg_idx_t        ent_rd_i [scb_cfg_pkg::NUM_UNITS],
    output logic                    dec0_stall_o,
    output logic                    dec1_stall_o,
    output scb_cfg_pkg::unit_mask_t dec0_unit_o,
    output scb_cfg_pkg::unit_mask_t dec1_unit_o,
    output scb_cfg_pkg::sid_t       dec0_sid_o,
    output scb_cfg_pkg::sid_t       dec1_sid_o
);

    import scb_cfg_pkg::*;
    import rv_pkg::*;

    sid_t       sid_q;
    unit_mask_t pick0;
    unit_mask_t pick1;
    logic       waw0;
    logic       waw1;
    logic       pair_rd;
    logic       accept0;
    logic       accept1;

    // first free unit of the class, ALU0 before ALU1
    function automatic unit_mask_t pick_unit(exe_class_t cls, unit_mask_t free);
        unit_mask_t sel;
        sel = '0;
        if (cls[CLS_ALU]) begin
            if (free[UNIT_ALU0]) begin
                sel[UNIT_ALU0] = 1'b1;
            end else if (free[UNIT_ALU1]) begin
                sel[UNIT_ALU1] = 1'b1;
            end
        end else if (cls[CLS_BEU]) begin
            sel[UNIT_BEU] = free[UNIT_BEU];
        end else if (cls[CLS_LSU]) begin
            sel[UNIT_LSU] = free[UNIT_LSU];
        end
        return sel;
    endfunction

    // destination already owned by an in-flight instruction
    always_comb begin
        waw0 = 1'b0;
        waw1 = 1'b0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (busy_i[u] && ent_rd_i[u] == dec0_rd_i) begin
                waw0 = 1'b1;
            end
            if (busy_i[u] && ent_rd_i[u] == dec1_rd_i) begin
                waw1 = 1'b1;
            end
        end
    end

    assign pick0 = pick_unit(dec0_class_i, ~busy_i);
    // slot 1 cannot take what slot 0 is granted
    assign pick1 = pick_unit(dec1_class_i, ~busy_i & ~dec0_unit_o);

    assign pair_rd = dec0_vld_i && (dec0_rd_i == dec1_rd_i);

    assign dec0_stall_o = dec0_vld_i && ((pick0 == '0) || waw0 || op_stall0_i);

    assign dec1_stall_o = dec1_vld_i &&
                          ((pick1 == '0) || waw1 || op_stall1_i || pair_rd || dec0_stall_o);

    assign accept0 = dec0_vld_i && !dec0_stall_o;
    assign accept1 = dec1_vld_i && !dec1_stall_o;

    assign dec0_unit_o = accept0 ? pick0 : '0;
    assign dec1_unit_o = accept1 ? pick1 : '0;

    assign dec0_sid_o = sid_q;
    assign dec1_sid_o = sid_q + sid_t'(1);

    // slot 1 always consumes counter+1, so step past it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sid_q <= '0;
        end else if (accept1) begin
            sid_q <= sid_q + sid_t'(2);
        end else if (accept0) begin
            sid_q <= sid_q + sid_t'(1);
        end
    end

endmodule

// ==== design/raw_check.sv ====
`timescale 1ns/100ps

module raw_check (
    input  logic                    op0_vld_i,
    input  logic                    op1_vld_i,
    input  scb_cfg_pkg::sid_t       op0_sid_i,
    input  scb_cfg_pkg::sid_t       op1_sid_i,
    input  rv_pkg::reg_idx_t        op0_rd_i,
    input  rv_pkg::reg_idx_t        op1_rd_i,
    input  rv_pkg::reg_idx_t        op0_rs1_i,
    input  rv_pkg::reg_idx_t        op0_rs2_i,
    input  rv_pkg::reg_idx_t        op1_rs1_i,
    input  rv_pkg::reg_idx_t        op1_rs2_i,
    input  scb_cfg_pkg::unit_mask_t busy_i,
    input  rv_pkg::reg_idx_t        ent_rd_i [scb_cfg_pkg::NUM_UNITS],
    input  scb_cfg_pkg::sid_t       ent_sid_i [scb_cfg_pkg::NUM_UNITS],
    output logic                    op0_stall_o,
    output logic                    op1_stall_o
);

    import scb_cfg_pkg::*;
    import rv_pkg::*;

    logic ent_raw0;
    logic ent_raw1;
    logic pair_raw0;
    logic pair_raw1;

    function automatic logic src_hit(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return (rd == rs1) || (rd == rs2);
    endfunction

    // only an older producer blocks the read
    always_comb begin
        ent_raw0 = 1'b0;
        ent_raw1 = 1'b0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (busy_i[u] && src_hit(ent_rd_i[u], op0_rs1_i, op0_rs2_i) &&
                sid_newer(op0_sid_i, ent_sid_i[u])) begin
                ent_raw0 = 1'b1;
            end
            if (busy_i[u] && src_hit(ent_rd_i[u], op1_rs1_i, op1_rs2_i) &&
                sid_newer(op1_sid_i, ent_sid_i[u])) begin
                ent_raw1 = 1'b1;
            end
        end
    end

    // paired slot producing a source this cycle
    assign pair_raw0 = op1_vld_i && src_hit(op1_rd_i, op0_rs1_i, op0_rs2_i) &&
                       sid_newer(op0_sid_i, op1_sid_i);
    assign pair_raw1 = op0_vld_i && src_hit(op0_rd_i, op1_rs1_i, op1_rs2_i) &&
                       sid_newer(op1_sid_i, op0_sid_i);

    assign op0_stall_o = op0_vld_i && (ent_raw0 || pair_raw0);
    assign op1_stall_o = op1_vld_i && (ent_raw1 || pair_raw1);

endmodule

// ==== design/wb_release.sv ====
`timescale 1ns/100ps

module wb_release (
    input  logic                    wb0_vld_i,
    input  logic                    wb1_vld_i,
    input  scb_cfg_pkg::sid_t       wb0_sid_i,
    input  scb_cfg_pkg::sid_t       wb1_sid_i,
    input  rv_pkg::reg_idx_t        wb0_rd_i,
    input  rv_pkg::reg_idx_t        wb1_rd_i,
    input  scb_cfg_pkg::sid_t       ent_sid_i [scb_cfg_pkg::NUM_UNITS],
    output logic                    wb0_stall_o,
    output logic                    wb1_stall_o,
    output scb_cfg_pkg::unit_mask_t release_o
);

    import scb_cfg_pkg::*;

    logic same_rd;
    logic wb0_go;
    logic wb1_go;

    // two writes to one register, the older one goes first
    assign same_rd = wb0_vld_i && wb1_vld_i && (wb0_rd_i == wb1_rd_i);

    assign wb0_stall_o = same_rd && sid_newer(wb0_sid_i, wb1_sid_i);
    assign wb1_stall_o = same_rd && sid_newer(wb1_sid_i, wb0_sid_i);

    assign wb0_go = wb0_vld_i && !wb0_stall_o;
    assign wb1_go = wb1_vld_i && !wb1_stall_o;

    // free the unit whose record carries the written sid
    always_comb begin
        release_o = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (wb0_go && wb0_sid_i == ent_sid_i[u]) begin
                release_o[u] = 1'b1;
            end
            if (wb1_go && wb1_sid_i == ent_sid_i[u]) begin
                release_o[u] = 1'b1;
            end
        end
    end

endmodule

// ==== design/scoreboard.sv ====
`timescale 1ns/100ps

module scoreboard (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec0_vld_i,
    input  rv_pkg::exe_class_t      dec0_class_i,
    input  rv_pkg::reg_idx_t        dec0_rd_i,
    input  rv_pkg::reg_idx_t        dec0_rs1_i,
    input  rv_pkg::reg_idx_t        dec0_rs2_i,
    input  logic                    dec1_vld_i,
    input  rv_pkg::exe_class_t      dec1_class_i,
    input  rv_pkg::reg_idx_t        dec1_rd_i,
    input  rv_pkg::reg_idx_t        dec1_rs1_i,
    input  rv_pkg::reg_idx_t        dec1_rs2_i,
    output logic                    dec0_stall_o,
    output logic                    dec1_stall_o,
    output scb_cfg_pkg::sid_t       dec0_sid_o,
    output scb_cfg_pkg::sid_t       dec1_sid_o,
    output scb_cfg_pkg::unit_mask_t dec0_unit_o,
    output scb_cfg_pkg::unit_mask_t dec1_unit_o,
    input  logic                    op0_vld_i,
    input  scb_cfg_pkg::sid_t       op0_sid_i,
    input  rv_pkg::reg_idx_t        op0_rd_i,
    input  rv_pkg::reg_idx_t        op0_rs1_i,
    input  rv_pkg::reg_idx_t        op0_rs2_i,
    input  logic                    op1_vld_i,
    input  scb_cfg_pkg::sid_t       op1_sid_i,
    input  rv_pkg::reg_idx_t        op1_rd_i,
    input  rv_pkg::reg_idx_t        op1_rs1_i,
    input  rv_pkg::reg_idx_t        op1_rs2_i,
    output logic                    op0_stall_o,
    output logic                    op1_stall_o,
    input  logic                    wb0_vld_i,
    input  scb_cfg_pkg::sid_t       wb0_sid_i,
    input  rv_pkg::reg_idx_t        wb0_rd_i,
    input  logic                    wb1_vld_i,
    input  scb_cfg_pkg::sid_t       wb1_sid_i,
    input  rv_pkg::reg_idx_t        wb1_rd_i,
    output logic                    wb0_stall_o,
    output logic                    wb1_stall_o
);

    import scb_cfg_pkg::*;
    import rv_pkg::*;

    unit_mask_t busy;
    unit_mask_t release_mask;
    reg_idx_t   ent_rd [NUM_UNITS];
    sid_t       ent_sid [NUM_UNITS];

    // grants are exclusive, slot 0 fields win when it holds the unit
    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_entry
        scb_entry i_entry (
            .clk         (clk),
            .rst_n       (rst_n),
            .alloc_i     (dec0_unit_o[u] | dec1_unit_o[u]),
            .alloc_rd_i  (dec0_unit_o[u] ? dec0_rd_i : dec1_rd_i),
            .alloc_sid_i (dec0_unit_o[u] ? dec0_sid_o : dec1_sid_o),
            .release_i   (release_mask[u]),
            .busy_o      (busy[u]),
            .rd_o        (ent_rd[u]),
            .sid_o       (ent_sid[u])
        );
    end

    issue_ctrl i_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec0_vld_i   (dec0_vld_i),
        .dec0_class_i (dec0_class_i),
        .dec0_rd_i    (dec0_rd_i),
        .dec1_vld_i   (dec1_vld_i),
        .dec1_class_i (dec1_class_i),
        .dec1_rd_i    (dec1_rd_i),
        .op_stall0_i  (op0_stall_o),
        .op_stall1_i  (op1_stall_o),
        .busy_i       (busy),
        .ent_rd_i     (ent_rd),
        .dec0_stall_o (dec0_stall_o),
        .dec1_stall_o (dec1_stall_o),
        .dec0_unit_o  (dec0_unit_o),
        .dec1_unit_o  (dec1_unit_o),
        .dec0_sid_o   (dec0_sid_o),
        .dec1_sid_o   (dec1_sid_o)
    );

    raw_check i_raw (
        .op0_vld_i   (op0_vld_i),
        .op1_vld_i   (op1_vld_i),
        .op0_sid_i   (op0_sid_i),
        .op1_sid_i   (op1_sid_i),
        .op0_rd_i    (op0_rd_i),
        .op1_rd_i    (op1_rd_i),
        .op0_rs1_i   (op0_rs1_i),
        .op0_rs2_i   (op0_rs2_i),
        .op1_rs1_i   (op1_rs1_i),
        .op1_rs2_i   (op1_rs2_i),
        .busy_i      (busy),
        .ent_rd_i    (ent_rd),
        .ent_sid_i   (ent_sid),
        .op0_stall_o (op0_stall_o),
        .op1_stall_o (op1_stall_o)
    );

    wb_release i_wb (
        .wb0_vld_i   (wb0_vld_i),
        .wb1_vld_i   (wb1_vld_i),
        .wb0_sid_i   (wb0_sid_i),
        .wb1_sid_i   (wb1_sid_i),
        .wb0_rd_i    (wb0_rd_i),
        .wb1_rd_i    (wb1_rd_i),
        .ent_sid_i   (ent_sid),
        .wb0_stall_o (wb0_stall_o),
        .wb1_stall_o (wb1_stall_o),
        .release_o   (release_mask)
    );

endmodule

// ==== testbench/tb_vectors.svh ====
add_row("idle after reset", '0, '0, '0, '0, '0, '0,
        expected(0, 0, 0, 1, 'h0, 'h0, 0, 0, 0, 0));
add_row("alu pair after reset", dec_in(CLS_ALU, 1, 0, 0), dec_in(CLS_ALU, 2, 0, 0),
        '0, '0, '0, '0, expected(0, 0, 0, 1, 'h1, 'h2, 0, 0, 0, 0));
add_row("alu class full", dec_in(CLS_ALU, 3, 0, 0), dec_in(CLS_BEU, 4, 0, 0),
        '0, '0, '0, '0, expected(1, 1, 2, 3, 'h0, 'h0, 0, 0, 0, 0));
add_row("beu lsu pair", dec_in(CLS_BEU, 3, 1, 2), dec_in(CLS_LSU, 4, 3, 0),
        '0, '0, '0, '0, expected(0, 0, 2, 3, 'h4, 'h8, 0, 0, 0, 0));
add_row("release alu0 and beu", '0, '0, '0, '0, wb_in(0, 1), wb_in(2, 3),
        expected(0, 0, 4, 5, 'h0, 'h0, 0, 0, 0, 0));
// WAW against a busy entry and inside the pair
add_row("waw on busy rd", dec_in(CLS_ALU, 2, 0, 0), dec_in(CLS_BEU, 6, 0, 0),
        '0, '0, '0, '0, expected(1, 1, 4, 5, 'h0, 'h0, 0, 0, 0, 0));
add_row("waw within pair", dec_in(CLS_ALU, 5, 0, 0), dec_in(CLS_BEU, 5, 0, 0),
        '0, '0, '0, '0, expected(0, 1, 4, 5, 'h1, 'h0, 0, 0, 0, 0));
add_row("raw on older entry", dec_in(CLS_BEU, 8, 0, 0), '0, op_in(6, 7, 5, 0), '0,
        '0, '0, expected(1, 0, 5, 6, 'h0, 'h0, 1, 0, 0, 0));
add_row("raw on newer entry", dec_in(CLS_BEU, 8, 0, 0), '0, op_in(2, 7, 5, 0), '0,
        '0, '0, expected(0, 0, 5, 6, 'h4, 'h0, 0, 0, 0, 0));
add_row("raw on paired slot", '0, '0, op_in(6, 9, 12, 0), op_in(7, 12, 9, 0),
        '0, '0, expected(0, 0, 6, 7, 'h0, 'h0, 0, 1, 0, 0));
add_row("wb same rd ordering", '0, '0, '0, '0, wb_in(4, 5), wb_in(1, 5),
        expected(0, 0, 6, 7, 'h0, 'h0, 0, 0, 1, 0));
add_row("release clears waw", dec_in(CLS_ALU, 2, 0, 0), '0, '0, '0, wb_in(4, 5), '0,
        expected(0, 0, 6, 7, 'h2, 'h0, 0, 0, 0, 0));
add_row("slot 1 skips slot 0 unit", dec_in(CLS_ALU, 14, 0, 0), dec_in(CLS_ALU, 15, 0, 0),
        '0, '0, wb_in(5, 8), wb_in(3, 4), expected(0, 1, 7, 8, 'h1, 'h0, 0, 0, 0, 0));
// alternate unit pairs until the counter crosses 16
add_row("wrap step sid 8", dec_in(CLS_BEU, 16, 0, 0), dec_in(CLS_LSU, 17, 0, 0),
        '0, '0, wb_in(7, 14), wb_in(6, 2), expected(0, 0, 8, 9, 'h4, 'h8, 0, 0, 0, 0));
add_row("wrap step sid 10", dec_in(CLS_ALU, 18, 0, 0), dec_in(CLS_ALU, 19, 0, 0),
        '0, '0, wb_in(8, 16), wb_in(9, 17), expected(0, 0, 10, 11, 'h1, 'h2, 0, 0, 0, 0));
add_row("wrap step sid 12", dec_in(CLS_BEU, 20, 0, 0), dec_in(CLS_LSU, 21, 0, 0),
        '0, '0, wb_in(10, 18), wb_in(11, 19), expected(0, 0, 12, 13, 'h4, 'h8, 0, 0, 0, 0));
add_row("wrap step sid 14", dec_in(CLS_ALU, 22, 0, 0), dec_in(CLS_ALU, 23, 0, 0),
        '0, '0, wb_in(12, 20), wb_in(13, 21), expected(0, 0, 14, 15, 'h1, 'h2, 0, 0, 0, 0));
add_row("wrap step sid 16", dec_in(CLS_BEU, 24, 0, 0), dec_in(CLS_LSU, 25, 0, 0),
        '0, '0, wb_in(14, 22), wb_in(15, 23), expected(0, 0, 16, 17, 'h4, 'h8, 0, 0, 0, 0));
// decoder slot 1 held by its operand slot
add_row("raw across wrap", dec_in(CLS_ALU, 28, 0, 0), dec_in(CLS_ALU, 29, 0, 0),
        op_in(15, 26, 24, 0), op_in(18, 27, 25, 0),
        '0, '0, expected(0, 1, 18, 19, 'h1, 'h0, 0, 1, 0, 0));
add_row("wb order across wrap", '0, '0, '0, '0, wb_in(16, 30), wb_in(15, 30),
        expected(0, 0, 19, 20, 'h0, 'h0, 0, 0, 1, 0));
add_row("idle at end", '0, '0, '0, '0, '0, '0,
        expected(0, 0, 19, 20, 'h0, 'h0, 0, 0, 0, 0));

// ==== testbench/tb_scoreboard.sv ====
`timescale 1ns/100ps

module tb_scoreboard;

    import scb_cfg_pkg::*;
    import rv_pkg::*;

    localparam int RESET_TIMEOUT = 16;

    typedef struct packed {
        logic       vld;
        exe_class_t cls;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
    } dec_in_t;

    typedef struct packed {
        logic     vld;
        sid_t     sid;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } op_in_t;

    typedef struct packed {
        logic     vld;
        sid_t     sid;
        reg_idx_t rd;
    } wb_in_t;

    typedef struct packed {
        logic       dec0_stall;
        logic       dec1_stall;
        sid_t       dec0_sid;
        sid_t       dec1_sid;
        unit_mask_t dec0_unit;
        unit_mask_t dec1_unit;
        logic       op0_stall;
        logic       op1_stall;
        logic       wb0_stall;
        logic       wb1_stall;
    } out_t;

    logic       clk = 1'b0;
    logic       rst_n;
    dec_in_t    dec0;
    dec_in_t    dec1;
    op_in_t     op0;
    op_in_t     op1;
    wb_in_t     wb0;
    wb_in_t     wb1;
    logic       dec0_stall;
    logic       dec1_stall;
    sid_t       dec0_sid;
    sid_t       dec1_sid;
    unit_mask_t dec0_unit;
    unit_mask_t dec1_unit;
    logic       op0_stall;
    logic       op1_stall;
    logic       wb0_stall;
    logic       wb1_stall;

    string   names[$];
    dec_in_t dec0_rows[$];
    dec_in_t dec1_rows[$];
    op_in_t  op0_rows[$];
    op_in_t  op1_rows[$];
    wb_in_t  wb0_rows[$];
    wb_in_t  wb1_rows[$];
    out_t    out_rows[$];

    always #20 clk = ~clk;

    scoreboard i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec0_vld_i   (dec0.vld),
        .dec0_class_i (dec0.cls),
        .dec0_rd_i    (dec0.rd),
        .dec0_rs1_i   (dec0.rs1),
        .dec0_rs2_i   (dec0.rs2),
        .dec1_vld_i   (dec1.vld),
        .dec1_class_i (dec1.cls),
        .dec1_rd_i    (dec1.rd),
        .dec1_rs1_i   (dec1.rs1),
        .dec1_rs2_i   (dec1.rs2),
        .dec0_stall_o (dec0_stall),
        .dec1_stall_o (dec1_stall),
        .dec0_sid_o   (dec0_sid),
        .dec1_sid_o   (dec1_sid),
        .dec0_unit_o  (dec0_unit),
        .dec1_unit_o  (dec1_unit),
        .op0_vld_i    (op0.vld),
        .op0_sid_i    (op0.sid),
        .op0_rd_i     (op0.rd),
        .op0_rs1_i    (op0.rs1),
        .op0_rs2_i    (op0.rs2),
        .op1_vld_i    (op1.vld),
        .op1_sid_i    (op1.sid),
        .op1_rd_i     (op1.rd),
        .op1_rs1_i    (op1.rs1),
        .op1_rs2_i    (op1.rs2),
        .op0_stall_o  (op0_stall),
        .op1_stall_o  (op1_stall),
        .wb0_vld_i    (wb0.vld),
        .wb0_sid_i    (wb0.sid),
        .wb0_rd_i     (wb0.rd),
        .wb1_vld_i    (wb1.vld),
        .wb1_sid_i    (wb1.sid),
        .wb1_rd_i     (wb1.rd),
        .wb0_stall_o  (wb0_stall),
        .wb1_stall_o  (wb1_stall)
    );

    // valid decoder slot, cls is a CLS_* bit position
    function automatic dec_in_t dec_in(int cls, int rd, int rs1, int rs2);
        dec_in_t d;
        d.vld = 1'b1;
        d.cls = exe_class_t'(1) << cls;
        d.rd  = reg_idx_t'(rd);
        d.rs1 = reg_idx_t'(rs1);
        d.rs2 = reg_idx_t'(rs2);
        return d;
    endfunction

    function automatic op_in_t op_in(int sid, int rd, int rs1, int rs2);
        op_in_t o;
        o.vld = 1'b1;
        o.sid = sid_t'(sid);
        o.rd  = reg_idx_t'(rd);
        o.rs1 = reg_idx_t'(rs1);
        o.rs2 = reg_idx_t'(rs2);
        return o;
    endfunction

    function automatic wb_in_t wb_in(int sid, int rd);
        wb_in_t w;
        w.vld = 1'b1;
        w.sid = sid_t'(sid);
        w.rd  = reg_idx_t'(rd);
        return w;
    endfunction

    function automatic out_t expected(int ds0, int ds1, int sid0, int sid1, int u0, int u1,
                                      int os0, int os1, int ws0, int ws1);
        out_t e;
        e.dec0_stall = ds0[0];
        e.dec1_stall = ds1[0];
        e.dec0_sid   = sid_t'(sid0);
        e.dec1_sid   = sid_t'(sid1);
        e.dec0_unit  = unit_mask_t'(u0);
        e.dec1_unit  = unit_mask_t'(u1);
        e.op0_stall  = os0[0];
        e.op1_stall  = os1[0];
        e.wb0_stall  = ws0[0];
        e.wb1_stall  = ws1[0];
        return e;
    endfunction

    task automatic add_row(string name, dec_in_t d0, dec_in_t d1, op_in_t o0, op_in_t o1,
                           wb_in_t w0, wb_in_t w1, out_t e);
        names.push_back(name);
        dec0_rows.push_back(d0);
        dec1_rows.push_back(d1);
        op0_rows.push_back(o0);
        op1_rows.push_back(o1);
        wb0_rows.push_back(w0);
        wb1_rows.push_back(w1);
        out_rows.push_back(e);
    endtask

    // row: name, decoder 0/1, operand 0/1, writeback 0/1, expected outputs
    task automatic load_table();
`include "tb_vectors.svh"
    endtask

    task automatic apply_row(int i);
        dec0 <= dec0_rows[i];
        dec1 <= dec1_rows[i];
        op0  <= op0_rows[i];
        op1  <= op1_rows[i];
        wb0  <= wb0_rows[i];
        wb1  <= wb1_rows[i];
    endtask

    task automatic check_value(string test, string field, logic [31:0] want, logic [31:0] got);
        assert (got === want) else begin
            $display("** Error %s: %s expected 'h%0h, actual 'h%0h", test, field, want, got);
            $display("Test failed");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic check_row(int i);
        out_t want;
        want = out_rows[i];
        check_value(names[i], "dec0_stall", 32'(want.dec0_stall), 32'(dec0_stall));
        check_value(names[i], "dec1_stall", 32'(want.dec1_stall), 32'(dec1_stall));
        check_value(names[i], "dec0_sid", 32'(want.dec0_sid), 32'(dec0_sid));
        check_value(names[i], "dec1_sid", 32'(want.dec1_sid), 32'(dec1_sid));
        check_value(names[i], "dec0_unit", 32'(want.dec0_unit), 32'(dec0_unit));
        check_value(names[i], "dec1_unit", 32'(want.dec1_unit), 32'(dec1_unit));
        check_value(names[i], "op0_stall", 32'(want.op0_stall), 32'(op0_stall));
        check_value(names[i], "op1_stall", 32'(want.op1_stall), 32'(op1_stall));
        check_value(names[i], "wb0_stall", 32'(want.wb0_stall), 32'(wb0_stall));
        check_value(names[i], "wb1_stall", 32'(want.wb1_stall), 32'(wb1_stall));
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            cycles++;
            @(posedge clk);
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Test failed");
            $fatal(1, "reset release timeout");
        end
    endtask

    initial begin
        rst_n = 1'b0;
        dec0  = '0;
        dec1  = '0;
        op0   = '0;
        op1   = '0;
        wb0   = '0;
        wb1   = '0;
        load_table();
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
        wait_reset_release();
        for (int i = 0; i < names.size(); i++) begin
            @(posedge clk);
            apply_row(i);
            // sample 5 ns before the next edge
            #35;
            check_row(i);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+testbench
design/scb_cfg_pkg.sv
design/rv_pkg.sv
design/scb_entry.sv
design/issue_ctrl.sv
design/raw_check.sv
design/wb_release.sv
design/scoreboard.sv
testbench/tb_scoreboard.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module tb_scoreboard \
		-o tb_scoreboard

run: compile
	./obj_dir/tb_scoreboard > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
